//--- build.f
+incdir+include
source/cache_geom_pkg.sv
source/cache_lru_pkg.sv
source/cache_ports_if.sv
source/tag_memory.sv
source/age_memory.sv
source/lru_age_update.sv
source/tag_read_stage.sv
source/tag_compare_stage.sv
source/cache_bank_top.sv
tests/tb_clock_gen.sv
tests/cache_bank_tb.sv

//--- include/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// --------------------------------------------------------------------------
// line address fields
// --------------------------------------------------------------------------
`define X_LINE_BITS      6      // line column
`define Y_LINE_BITS      6      // line row
`define REF_BITS         4      // reference picture index

// --------------------------------------------------------------------------
// bank geometry
// --------------------------------------------------------------------------
`define SET_BITS         4      // 16 sets
`define WAY_BITS         2      // 4 ways
`define N_SETS           (1 << `SET_BITS)
`define N_WAYS           (1 << `WAY_BITS)

// axi side
`define LINE_BYTES_LOG2  6      // 64 byte lines
`define AXI_ADDR_BITS    32

`endif

//--- source/age_memory.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_settings.svh"

module age_memory (
   input  wire       clk,
   input  wire       reset,
   age_port_if.mem   age_port
);

   cache_lru_pkg::age_vec_t ages [`N_SETS];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int s = 0; s < `N_SETS; s++) begin
            for (int w = 0; w < `N_WAYS; w++) begin
               ages[s][w] <= cache_lru_pkg::age_t'(w);   // way 3 oldest
            end
         end
      end else if (age_port.wr_en) begin
         ages[age_port.wr_set] <= age_port.wr_ages;      // whole vector
      end
   end

   // write first on a set match
   always_comb begin
      if (age_port.wr_en && (age_port.wr_set == age_port.rd_set)) begin
         age_port.rd_ages = age_port.wr_ages;
      end else begin
         age_port.rd_ages = ages[age_port.rd_set];
      end
   end

endmodule

`default_nettype wire

//--- source/cache_bank_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_settings.svh"

module cache_bank_top (
   input  wire                        clk,
   input  wire                        reset,
   input  wire                        req_valid,
   input  wire [`REF_BITS-1:0]        req_ref_idx,
   input  wire [`X_LINE_BITS-1:0]     req_x,
   input  wire [`Y_LINE_BITS-1:0]     req_y,
   input  wire                        miss_fifo_full,
   input  wire                        hit_fifo_full,
   output logic                       req_ready,
   output logic                       hit_wr_en,
   output logic                       miss_wr_en,
   output cache_lru_pkg::way_t        result_way,
   output cache_geom_pkg::set_t       result_set,
   output cache_geom_pkg::axi_addr_t  ar_addr
);

   cache_geom_pkg::line_addr_u req_addr;
   cache_geom_pkg::line_addr_u s1_addr;
   logic                       s1_valid;
   logic                       advance;

   tag_port_if tag_port ();
   age_port_if age_port ();

   // image position packed into the line word
   assign req_addr.line = '{ref_idx: req_ref_idx, y_line: req_y, x_line: req_x};

   tag_read_stage i_tag_read_stage (
      .clk       (clk),
      .reset     (reset),
      .req_valid (req_valid),
      .req_addr  (req_addr),
      .advance   (advance),
      .req_ready (req_ready),
      .s1_valid  (s1_valid),
      .s1_addr   (s1_addr),
      .tag_port  (tag_port.addr),
      .age_port  (age_port.addr)
   );

   tag_compare_stage i_tag_compare_stage (
      .clk            (clk),
      .reset          (reset),
      .s1_valid       (s1_valid),
      .s1_addr        (s1_addr),
      .miss_fifo_full (miss_fifo_full),
      .hit_fifo_full  (hit_fifo_full),
      .advance        (advance),
      .hit_wr_en      (hit_wr_en),
      .miss_wr_en     (miss_wr_en),
      .result_way     (result_way),
      .result_set     (result_set),
      .ar_addr        (ar_addr),
      .tag_port       (tag_port.lookup),
      .age_port       (age_port.lookup)
   );

   tag_memory i_tag_memory (
      .clk      (clk),
      .reset    (reset),
      .tag_port (tag_port.mem)
   );

   age_memory i_age_memory (
      .clk      (clk),
      .reset    (reset),
      .age_port (age_port.mem)
   );

endmodule

`default_nettype wire

//--- source/cache_geom_pkg.sv
`default_nettype none
`include "cache_settings.svh"

package cache_geom_pkg;

   typedef logic [`SET_BITS-1:0] set_t;
   typedef logic [`REF_BITS+`Y_LINE_BITS+`X_LINE_BITS-`SET_BITS-1:0] tag_t;
   typedef logic [`AXI_ADDR_BITS-1:0] axi_addr_t;

   // image position of one cache line
   typedef struct packed {
      logic [`REF_BITS-1:0]    ref_idx;
      logic [`Y_LINE_BITS-1:0] y_line;
      logic [`X_LINE_BITS-1:0] x_line;    // column sits in the low bits
   } line_fields_t;

   // same word as the tag pipeline sees it
   typedef struct packed {
      tag_t tag;
      set_t set_idx;                      // low column bits
   } lookup_fields_t;

   typedef union packed {
      line_fields_t   line;
      lookup_fields_t lookup;
   } line_addr_u;

endpackage

`default_nettype wire

//--- source/cache_lru_pkg.sv
`default_nettype none
`include "cache_settings.svh"

package cache_lru_pkg;

   typedef logic [`WAY_BITS-1:0] way_t;

   // 0 is most recent, 3 is oldest
   typedef logic [`WAY_BITS-1:0] age_t;

   // one entry per way, indexed by way
   typedef age_t [`N_WAYS-1:0] age_vec_t;
   typedef cache_geom_pkg::tag_t [`N_WAYS-1:0] tag_vec_t;
   typedef logic [`N_WAYS-1:0] valid_vec_t;

endpackage

`default_nettype wire

//--- source/cache_ports_if.sv
`timescale 1ns/1ps
`default_nettype none

// --------------------------------------------------------------------------
// tag memory port
// --------------------------------------------------------------------------
interface tag_port_if;

   cache_geom_pkg::set_t      rd_set;
   cache_lru_pkg::tag_vec_t   rd_tags;
   cache_lru_pkg::valid_vec_t rd_valid;
   logic                      wr_en;      // miss only
   cache_geom_pkg::set_t      wr_set;
   cache_lru_pkg::way_t       wr_way;
   cache_geom_pkg::tag_t      wr_tag;

   modport mem (
      input  rd_set, wr_en, wr_set, wr_way, wr_tag,
      output rd_tags, rd_valid
   );
   modport addr (output rd_set);
   modport lookup (
      output wr_en, wr_set, wr_way, wr_tag,
      input  rd_tags, rd_valid
   );

endinterface

// --------------------------------------------------------------------------
// age memory port
// --------------------------------------------------------------------------
interface age_port_if;

   cache_geom_pkg::set_t    rd_set;
   cache_lru_pkg::age_vec_t rd_ages;
   logic                    wr_en;        // every hit or miss
   cache_geom_pkg::set_t    wr_set;
   cache_lru_pkg::age_vec_t wr_ages;

   modport mem (input rd_set, wr_en, wr_set, wr_ages, output rd_ages);
   modport addr (output rd_set);
   modport lookup (output wr_en, wr_set, wr_ages, input rd_ages);

endinterface

`default_nettype wire

//--- source/lru_age_update.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_settings.svh"

module lru_age_update (
   input  wire                           hit,
   input  wire cache_lru_pkg::way_t      hit_way,
   input  wire cache_lru_pkg::age_vec_t  ages,
   output cache_lru_pkg::age_vec_t       new_ages,
   output cache_lru_pkg::way_t           victim_way
);

   cache_lru_pkg::way_t used_way;
   cache_lru_pkg::age_t used_age;

   // oldest way is the replacement candidate
   always_comb begin
      victim_way = '0;
      for (int w = 0; w < `N_WAYS; w++) begin
         if (ages[w] == '1) begin
            victim_way = cache_lru_pkg::way_t'(w);
         end
      end
   end

   assign used_way = hit ? hit_way : victim_way;
   assign used_age = ages[used_way];

   // everything younger than the used way ages by one
   always_comb begin
      for (int w = 0; w < `N_WAYS; w++) begin
         if (cache_lru_pkg::way_t'(w) == used_way) begin
            new_ages[w] = '0;                   // now most recent
         end else if (ages[w] < used_age) begin
            new_ages[w] = ages[w] + 1'b1;
         end else begin
            new_ages[w] = ages[w];
         end
      end
   end

endmodule

`default_nettype wire

//--- source/tag_compare_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_settings.svh"

module tag_compare_stage (
   input  wire                              clk,
   input  wire                              reset,
   input  wire                              s1_valid,
   input  wire cache_geom_pkg::line_addr_u  s1_addr,
   input  wire                              miss_fifo_full,
   input  wire                              hit_fifo_full,
   output logic                             advance,
   output logic                             hit_wr_en,
   output logic                             miss_wr_en,
   output cache_lru_pkg::way_t              result_way,
   output cache_geom_pkg::set_t             result_set,
   output cache_geom_pkg::axi_addr_t        ar_addr,
   tag_port_if.lookup                       tag_port,
   age_port_if.lookup                       age_port
);

   logic                    hit;
   logic                    capture;
   cache_lru_pkg::way_t     hit_way;
   cache_lru_pkg::way_t     victim_way;
   cache_lru_pkg::age_vec_t new_ages;
   cache_geom_pkg::tag_t    result_tag;
   cache_lru_pkg::age_vec_t result_ages;

   assign advance = !miss_fifo_full && !hit_fifo_full;
   assign capture = s1_valid && advance;

   // --------------------------------------------------------------------------
   // tag compare over all ways
   // --------------------------------------------------------------------------
   always_comb begin
      hit     = 1'b0;
      hit_way = '0;
      for (int w = 0; w < `N_WAYS; w++) begin
         if (tag_port.rd_valid[w] && (tag_port.rd_tags[w] == s1_addr.lookup.tag)) begin
            hit     = 1'b1;
            hit_way = cache_lru_pkg::way_t'(w);
         end
      end
   end

   lru_age_update i_lru_age_update (
      .hit        (hit),
      .hit_way    (hit_way),
      .ages       (age_port.rd_ages),
      .new_ages   (new_ages),
      .victim_way (victim_way)
   );

   // --------------------------------------------------------------------------
   // stage 2 result
   // --------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         hit_wr_en  <= 1'b0;
         miss_wr_en <= 1'b0;
      end else begin
         hit_wr_en  <= capture && hit;          // one pulse per request
         miss_wr_en <= capture && !hit;
      end
   end

   always_ff @(posedge clk) begin
      if (capture) begin
         result_way  <= hit ? hit_way : victim_way;
         result_set  <= s1_addr.lookup.set_idx;
         result_tag  <= s1_addr.lookup.tag;
         result_ages <= new_ages;
         ar_addr     <= cache_geom_pkg::axi_addr_t'(s1_addr) << `LINE_BYTES_LOG2;
      end
   end

   // write back from the registered result, lands at the next edge
   assign tag_port.wr_en   = miss_wr_en;        // fill the victim way
   assign tag_port.wr_set  = result_set;
   assign tag_port.wr_way  = result_way;
   assign tag_port.wr_tag  = result_tag;

   assign age_port.wr_en   = hit_wr_en || miss_wr_en;
   assign age_port.wr_set  = result_set;
   assign age_port.wr_ages = result_ages;

endmodule

`default_nettype wire

//--- source/tag_memory.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_settings.svh"

module tag_memory (
   input  wire       clk,
   input  wire       reset,
   tag_port_if.mem   tag_port
);

   cache_lru_pkg::tag_vec_t   tags  [`N_SETS];
   cache_lru_pkg::valid_vec_t valid [`N_SETS];

   // --------------------------------------------------------------------------
   // write side
   // --------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (tag_port.wr_en) begin
         tags[tag_port.wr_set][tag_port.wr_way] <= tag_port.wr_tag;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int s = 0; s < `N_SETS; s++) begin
            valid[s] <= '0;                    // all ways empty
         end
      end else if (tag_port.wr_en) begin
         valid[tag_port.wr_set][tag_port.wr_way] <= 1'b1;
      end
   end

   // --------------------------------------------------------------------------
   // read side
   // --------------------------------------------------------------------------
   // a fill landing on the set being read shows up in the same cycle,
   // so a back-to-back request for the same line sees it as a hit
   always_comb begin
      tag_port.rd_tags  = tags[tag_port.rd_set];
      tag_port.rd_valid = valid[tag_port.rd_set];
      if (tag_port.wr_en && (tag_port.wr_set == tag_port.rd_set)) begin
         tag_port.rd_tags[tag_port.wr_way]  = tag_port.wr_tag;
         tag_port.rd_valid[tag_port.wr_way] = 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- source/tag_read_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tag_read_stage (
   input  wire                              clk,
   input  wire                              reset,
   input  wire                              req_valid,
   input  wire cache_geom_pkg::line_addr_u  req_addr,
   input  wire                              advance,
   output logic                             req_ready,
   output logic                             s1_valid,
   output cache_geom_pkg::line_addr_u       s1_addr,
   tag_port_if.addr                         tag_port,
   age_port_if.addr                         age_port
);

   // free when empty or when stage 2 takes the current entry
   assign req_ready = !s1_valid || advance;

   always_ff @(posedge clk) begin
      if (reset) begin
         s1_valid <= 1'b0;
      end else if (req_ready) begin
         s1_valid <= req_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (req_valid && req_ready) begin
         s1_addr <= req_addr;
      end
   end

   // --------------------------------------------------------------------------
   // both memories are read with the stage 1 set
   // --------------------------------------------------------------------------
   assign tag_port.rd_set = s1_addr.lookup.set_idx;
   assign age_port.rd_set = s1_addr.lookup.set_idx;

endmodule

`default_nettype wire

//--- tests/cache_bank_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_settings.svh"

module cache_bank_tb;

   localparam int line_bits       = `REF_BITS + `Y_LINE_BITS + `X_LINE_BITS;
   localparam int cold_requests   = 2;
   localparam int lru_requests    = 7;
   localparam int b2b_requests    = 8;
   localparam int bp_requests     = 10;
   localparam int random_requests = 300;
   localparam int total_requests  = cold_requests + lru_requests + b2b_requests
                                    + bp_requests + random_requests;
   localparam int cycle_limit     = 2 * total_requests + 200;
   localparam logic [31:0] seed   = 32'h61d9_d030;

   typedef struct packed {
      logic                      is_hit;
      cache_lru_pkg::way_t       way;
      cache_geom_pkg::set_t      set_idx;
      cache_geom_pkg::axi_addr_t addr;
   } expected_t;

   logic                      clk;
   logic                      reset;
   logic                      req_valid;
   logic [`REF_BITS-1:0]      req_ref_idx;
   logic [`X_LINE_BITS-1:0]   req_x;
   logic [`Y_LINE_BITS-1:0]   req_y;
   logic                      miss_fifo_full;
   logic                      hit_fifo_full;
   logic                      req_ready;
   logic                      hit_wr_en;
   logic                      miss_wr_en;
   cache_lru_pkg::way_t       result_way;
   cache_geom_pkg::set_t      result_set;
   cache_geom_pkg::axi_addr_t ar_addr;

   // reference model state
   cache_geom_pkg::tag_t      model_tags  [`N_SETS][`N_WAYS];
   logic                      model_valid [`N_SETS][`N_WAYS];
   cache_lru_pkg::age_vec_t   model_ages  [`N_SETS];
   expected_t                 expected_q  [$];

   int          value_errors    = 0;
   int          protocol_errors = 0;
   int          cycle_count     = 0;
   logic        random_flags_on;
   logic [31:0] addr_state;
   logic [31:0] flag_state;

   tb_clock_gen i_tb_clock_gen (.clk(clk));

   cache_bank_top i_cache_bank_top (
      .clk            (clk),
      .reset          (reset),
      .req_valid      (req_valid),
      .req_ref_idx    (req_ref_idx),
      .req_x          (req_x),
      .req_y          (req_y),
      .miss_fifo_full (miss_fifo_full),
      .hit_fifo_full  (hit_fifo_full),
      .req_ready      (req_ready),
      .hit_wr_en      (hit_wr_en),
      .miss_wr_en     (miss_wr_en),
      .result_way     (result_way),
      .result_set     (result_set),
      .ar_addr        (ar_addr)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] state);
      logic [31:0] x;
      x = state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // ------------------------------------------------------------------------
   // reference model
   // ------------------------------------------------------------------------
   task automatic clear_model();
      for (int s = 0; s < `N_SETS; s++) begin
         for (int w = 0; w < `N_WAYS; w++) begin
            model_valid[s][w] = 1'b0;
            model_ages[s][w]  = cache_lru_pkg::age_t'(w);   // way 3 oldest
         end
      end
   endtask

   task automatic predict_access(input logic [line_bits-1:0] line);
      cache_geom_pkg::set_t    set_idx;
      cache_geom_pkg::tag_t    tag;
      cache_lru_pkg::way_t     used;
      cache_lru_pkg::age_vec_t old_ages;
      expected_t               expected;
      set_idx         = line[`SET_BITS-1:0];
      tag             = line[line_bits-1:`SET_BITS];
      old_ages        = model_ages[set_idx];
      expected.is_hit = 1'b0;
      used            = '0;
      for (int w = 0; w < `N_WAYS; w++) begin
         if (model_valid[set_idx][w] && model_tags[set_idx][w] == tag) begin
            expected.is_hit = 1'b1;
            used            = cache_lru_pkg::way_t'(w);
         end
      end
      if (!expected.is_hit) begin
         for (int w = 0; w < `N_WAYS; w++) begin
            if (old_ages[w] == cache_lru_pkg::age_t'(`N_WAYS - 1)) begin
               used = cache_lru_pkg::way_t'(w);             // oldest way refills
            end
         end
         model_tags[set_idx][used]  = tag;
         model_valid[set_idx][used] = 1'b1;
      end
      for (int w = 0; w < `N_WAYS; w++) begin
         if (w == used) begin
            model_ages[set_idx][w] = '0;
         end else if (old_ages[w] < old_ages[used]) begin
            model_ages[set_idx][w] = old_ages[w] + 1'b1;
         end
      end
      expected.way     = used;
      expected.set_idx = set_idx;
      expected.addr    = cache_geom_pkg::axi_addr_t'(line) * (32'd1 << `LINE_BYTES_LOG2);
      expected_q.push_back(expected);
   endtask

   // ------------------------------------------------------------------------
   // compare tasks
   // ------------------------------------------------------------------------
   task automatic check_kind(input logic got_hit, input logic exp_hit);
      if (got_hit !== exp_hit) begin
         $display("[FAIL] %0t ns hit_wr_en got %0b expected %0b", $time, got_hit, exp_hit);
         value_errors++;
      end
   endtask

   task automatic check_way(input cache_lru_pkg::way_t got, input cache_lru_pkg::way_t exp);
      if (got !== exp) begin
         $display("[FAIL] %0t ns result_way got %0d expected %0d", $time, got, exp);
         value_errors++;
      end
   endtask

   task automatic check_set(input cache_geom_pkg::set_t got, input cache_geom_pkg::set_t exp);
      if (got !== exp) begin
         $display("[FAIL] %0t ns result_set got %0d expected %0d", $time, got, exp);
         value_errors++;
      end
   endtask

   task automatic check_addr(input cache_geom_pkg::axi_addr_t got,
                             input cache_geom_pkg::axi_addr_t exp);
      if (got !== exp) begin
         $display("[FAIL] %0t ns ar_addr got %h expected %h", $time, got, exp);
         value_errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[FAIL] %0t ns %s got %0b expected %0b", $time, name, got, exp);
         value_errors++;
      end
   endtask

   task automatic print_error_counts();
      $display("errors: %0d wrong values, %0d protocol", value_errors, protocol_errors);
   endtask

   // results are stable for the whole cycle, sampled mid cycle
   always @(negedge clk) begin : result_monitor
      expected_t expected;
      if (!reset) begin
         if (hit_wr_en && miss_wr_en) begin
            $display("error at %0t ns: hit and miss strobes are high together", $time);
            protocol_errors++;
         end else if (hit_wr_en || miss_wr_en) begin
            if (expected_q.size() == 0) begin
               $display("error at %0t ns: result strobe with no pending request", $time);
               protocol_errors++;
            end else begin
               expected = expected_q.pop_front();
               check_kind(hit_wr_en, expected.is_hit);
               check_way(result_way, expected.way);
               check_set(result_set, expected.set_idx);
               check_addr(ar_addr, expected.addr);
            end
         end
      end
   end

   always @(negedge clk) begin
      if (random_flags_on) begin
         flag_state     = xorshift32(flag_state);
         hit_fifo_full  = (flag_state[2:0] == 3'd0);
         miss_fifo_full = (flag_state[5:3] == 3'd0);
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("timeout: no end of run after %0d cycles", cycle_limit);
         print_error_counts();
         $display("Verification failed");
         $finish;
      end
   end

   // ------------------------------------------------------------------------
   // stimulus, each task starts and ends on a falling edge
   // ------------------------------------------------------------------------
   task automatic send_request(input logic [`REF_BITS-1:0] ref_idx,
                               input logic [`Y_LINE_BITS-1:0] y,
                               input logic [`X_LINE_BITS-1:0] x);
      req_valid   = 1'b1;
      req_ref_idx = ref_idx;
      req_y       = y;
      req_x       = x;
      #1;
      while (req_ready !== 1'b1) begin
         @(negedge clk);
         #1;
      end
      predict_access({ref_idx, y, x});                    // accepted at next edge
      @(negedge clk);
      req_valid = 1'b0;
   endtask

   task automatic wait_for_results();
      while (expected_q.size() != 0) begin
         @(negedge clk);
         #1;
      end
      @(negedge clk);
   endtask

   task automatic test_reset_state();
      for (int i = 0; i < 3; i++) begin
         #1;
         check_flag("req_ready", req_ready, 1'b1);
         check_flag("hit_wr_en", hit_wr_en, 1'b0);
         check_flag("miss_wr_en", miss_wr_en, 1'b0);
         @(negedge clk);
      end
   endtask

   task automatic test_cold_miss_then_hit();
      send_request(4'd1, 6'd3, 6'd5);
      wait_for_results();
      send_request(4'd1, 6'd3, 6'd5);
      wait_for_results();
   endtask

   task automatic test_lru_eviction();
      for (int k = 0; k < 5; k++) begin
         send_request(4'd2, 6'(k), 6'd7);                 // five tags, set 7
         wait_for_results();
      end
      send_request(4'd2, 6'd0, 6'd7);
      wait_for_results();
      send_request(4'd2, 6'd4, 6'd7);
      wait_for_results();
   endtask

   task automatic test_back_to_back();
      send_request(4'd3, 6'd1, 6'd9);
      send_request(4'd3, 6'd1, 6'd9);
      send_request(4'd3, 6'd2, 6'd9);
      send_request(4'd3, 6'd3, 6'd9);
      send_request(4'd3, 6'd1, 6'd9);
      send_request(4'd3, 6'd2, 6'd9);
      send_request(4'd3, 6'd5, 6'd10);
      send_request(4'd3, 6'd5, 6'd10);
      wait_for_results();
   endtask

   task automatic test_back_pressure(input logic on_hit_flag, input int base_y);
      fork
         begin
            for (int k = 0; k < bp_requests / 2; k++) begin
               send_request(4'd5, 6'(base_y + k), 6'd12);
            end
         end
         begin
            repeat (2) @(negedge clk);                    // two requests in flight
            if (on_hit_flag) begin
               hit_fifo_full = 1'b1;
            end else begin
               miss_fifo_full = 1'b1;
            end
            for (int i = 0; i < 8; i++) begin
               @(negedge clk);
               #1;
               if (hit_wr_en || miss_wr_en) begin
                  $display("error at %0t ns: result strobe while a FIFO is full", $time);
                  protocol_errors++;
               end
            end
            check_flag("req_ready", req_ready, 1'b0);
            @(negedge clk);
            hit_fifo_full  = 1'b0;
            miss_fifo_full = 1'b0;
         end
      join
      wait_for_results();
   endtask

   task automatic test_random_traffic();
      @(posedge clk);
      random_flags_on = 1'b1;
      @(negedge clk);
      for (int i = 0; i < random_requests; i++) begin
         addr_state = xorshift32(addr_state);
         send_request({3'b000, addr_state[0]}, {5'b00000, addr_state[1]},
                      {addr_state[3:2], 2'b00, addr_state[5:4]});   // sets 0 to 3
      end
      @(posedge clk);
      random_flags_on = 1'b0;
      @(negedge clk);
      hit_fifo_full  = 1'b0;
      miss_fifo_full = 1'b0;
      wait_for_results();
   endtask

   initial begin
      reset           = 1'b1;
      req_valid       = 1'b0;
      req_ref_idx     = '0;
      req_x           = '0;
      req_y           = '0;
      miss_fifo_full  = 1'b0;
      hit_fifo_full   = 1'b0;
      random_flags_on = 1'b0;
      addr_state      = seed;
      flag_state      = ~seed;
      clear_model();
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      test_reset_state();
      test_cold_miss_then_hit();
      test_lru_eviction();
      test_back_to_back();
      test_back_pressure(1'b1, 0);
      test_back_pressure(1'b0, 2);
      test_random_traffic();
      repeat (4) @(negedge clk);                          // catch stray strobes
      if (expected_q.size() != 0) begin
         $display("error: %0d results never arrived", expected_q.size());
         protocol_errors++;
      end
      print_error_counts();
      if (value_errors == 0 && protocol_errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter real half_period = 2.0       // 4 ns clock
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #(half_period) clk = ~clk;
   end

endmodule

`default_nettype wire
